/* Bender.yml */
package:
  name: la_mmu

dependencies: {}

sources:
  - la_mmu_pkg.sv
  - la_csr_pkg.sv
  - tlb_lookup_if.sv
  - mmu_csr_regs.sv
  - tlb_array.sv
  - addr_translate.sv
  - mmu_top.sv
  - target: simulation
    files:
      - tb_mmu.sv

/* addr_translate.sv */
`timescale 1ns/10ps
`default_nettype none

module addr_translate
    import la_mmu_pkg::*;
    import la_csr_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,

    // request strobe
    input  wire         req_valid,
    input  wire  [31:0] req_va,
    input  req_kind_t   req_kind,

    // CSR values
    input  wire  [31:0] crmd,
    input  wire  [31:0] asid,
    input  wire  [31:0] dmw0,
    input  wire  [31:0] dmw1,

    tlb_lookup_if.requester tlb,

    // registered response
    output logic        resp_valid,
    output logic [31:0] resp_pa,
    output logic        resp_cacheable,
    output logic        resp_tlb_map,
    output mmu_exc_t    resp_exc
);

    logic [1:0]  cur_plv;
    logic [3:0]  dmw0_plv_en;
    logic [3:0]  dmw1_plv_en;
    logic        direct_mode;
    logic        map_mode;
    logic        dmw0_hit;
    logic        dmw1_hit;
    logic        tlb_map;
    logic [31:0] tlb_pa;
    logic [31:0] pa;
    logic        cacheable;
    mmu_exc_t    exc;

    assign cur_plv     = crmd[crmd_plv_msb:crmd_plv_lsb];
    assign direct_mode = crmd[crmd_da] & ~crmd[crmd_pg];
    assign map_mode    = ~crmd[crmd_da] & crmd[crmd_pg];

    // window match on the top three address bits
    assign dmw0_plv_en = dmw0[dmw_plv_msb:dmw_plv_lsb];
    assign dmw1_plv_en = dmw1[dmw_plv_msb:dmw_plv_lsb];
    assign dmw0_hit = map_mode & dmw0_plv_en[cur_plv] &
                      (dmw0[dmw_vseg_msb:dmw_vseg_lsb] == req_va[31:29]);
    assign dmw1_hit = map_mode & dmw1_plv_en[cur_plv] &
                      (dmw1[dmw_vseg_msb:dmw_vseg_lsb] == req_va[31:29]);
    assign tlb_map  = map_mode & ~dmw0_hit & ~dmw1_hit;

    // TLB query, answered in the same cycle
    assign tlb.vppn     = req_va[31:13];
    assign tlb.va_bit12 = req_va[12];
    assign tlb.asid     = asid[asid_msb:asid_lsb];

    assign tlb_pa = (tlb.ps == ps_2m) ? {tlb.ppn[19:9], req_va[20:0]}
                                      : {tlb.ppn, req_va[11:0]};

    always_comb begin
        if (direct_mode) begin
            pa        = req_va;
            cacheable = crmd[crmd_datm_lsb];
        end else if (dmw0_hit) begin
            pa        = {dmw0[dmw_pseg_msb:dmw_pseg_lsb], req_va[28:0]};
            cacheable = dmw0[dmw_mat];
        end else if (dmw1_hit) begin
            pa        = {dmw1[dmw_pseg_msb:dmw_pseg_lsb], req_va[28:0]};
            cacheable = dmw1[dmw_mat];
        end else begin
            pa        = tlb_pa;
            cacheable = tlb.mat[0];
        end
    end

    // one code per request, highest priority first
    always_comb begin
        if (!tlb_map) begin
            exc = exc_none;
        end else if (!tlb.found) begin
            exc = exc_tlbr;
        end else if (!tlb.v) begin
            exc = exc_pix;
        end else if (cur_plv > tlb.plv) begin
            exc = exc_ppi;
        end else if ((req_kind == req_store) && !tlb.d) begin
            exc = exc_pme;
        end else begin
            exc = exc_none;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp_pa        <= pa;
            resp_cacheable <= cacheable;
            resp_tlb_map   <= tlb_map;
            resp_exc       <= exc;
        end
    end

endmodule

`default_nettype wire

/* la_csr_pkg.sv */
`default_nettype none

package la_csr_pkg;

    // CSR numbers
    localparam logic [13:0] csr_crmd = 14'h000;
    localparam logic [13:0] csr_asid = 14'h018;
    localparam logic [13:0] csr_dmw0 = 14'h180;
    localparam logic [13:0] csr_dmw1 = 14'h181;

    // CRMD fields
    localparam int crmd_plv_lsb  = 0;
    localparam int crmd_plv_msb  = 1;
    localparam int crmd_da       = 3;
    localparam int crmd_pg       = 4;
    localparam int crmd_datm_lsb = 7;
    localparam int crmd_datm_msb = 8;

    // ASID field
    localparam int asid_lsb = 0;
    localparam int asid_msb = 9;

    // DMW fields, one plv enable bit per privilege level
    localparam int dmw_plv_lsb  = 0;
    localparam int dmw_plv_msb  = 3;
    localparam int dmw_mat      = 4;
    localparam int dmw_pseg_lsb = 25;
    localparam int dmw_pseg_msb = 27;
    localparam int dmw_vseg_lsb = 29;
    localparam int dmw_vseg_msb = 31;

    // writable bits per register layout
    localparam logic [31:0] crmd_wmask = 32'h0000_01ff;
    localparam logic [31:0] asid_wmask = 32'h0000_03ff;
    localparam logic [31:0] dmw_wmask  = 32'hee00_003f;

    // direct address mode at plv 0 out of reset
    localparam logic [31:0] crmd_reset = 32'h0000_0008;

endpackage

`default_nettype wire

/* la_mmu_pkg.sv */
`default_nettype none

package la_mmu_pkg;

    // page size codes as held in the ps field
    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_2m = 6'd21;

    // one TLB entry, an even/odd page pair behind a single vppn tag
    typedef struct packed {
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic        g;
        logic [9:0]  asid;
        logic        e;
        // even page
        logic [19:0] ppn0;
        logic [1:0]  plv0;
        logic [1:0]  mat0;
        logic        d0;
        logic        v0;
        // odd page
        logic [19:0] ppn1;
        logic [1:0]  plv1;
        logic [1:0]  mat1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    // kind of access behind a translation request
    typedef enum logic [1:0] {
        req_fetch = 2'd0,
        req_load  = 2'd1,
        req_store = 2'd2
    } req_kind_t;

    // translation exception, one code per response
    typedef enum logic [2:0] {
        exc_none = 3'd0,
        exc_tlbr = 3'd1,
        exc_pix  = 3'd2,
        exc_ppi  = 3'd3,
        exc_pme  = 3'd4
    } mmu_exc_t;

endpackage

`default_nettype wire

/* mmu_csr_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module mmu_csr_regs
    import la_csr_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,

    // strobe write port
    input  wire         csr_we,
    input  wire  [13:0] csr_addr,
    input  wire  [31:0] csr_wdata,

    // full register values toward translation
    output logic [31:0] crmd,
    output logic [31:0] asid,
    output logic [31:0] dmw0,
    output logic [31:0] dmw1
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd <= crmd_reset;
            asid <= '0;
            dmw0 <= '0;
            dmw1 <= '0;
        end else if (csr_we) begin
            // reserved bits always read back as zero
            case (csr_addr)
                csr_crmd: begin
                    crmd <= csr_wdata & crmd_wmask;
                end
                csr_asid: begin
                    asid <= csr_wdata & asid_wmask;
                end
                csr_dmw0: begin
                    dmw0 <= csr_wdata & dmw_wmask;
                end
                csr_dmw1: begin
                    dmw1 <= csr_wdata & dmw_wmask;
                end
                default: begin
                    // other CSR numbers live outside this block
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* mmu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mmu_top
    import la_mmu_pkg::*;
#(
    parameter int tlb_entries = 16
) (
    input  wire                            clk,
    input  wire                            rst_n,

    // CSR write
    input  wire                            csr_we,
    input  wire  [13:0]                    csr_addr,
    input  wire  [31:0]                    csr_wdata,

    // TLB fill
    input  wire                            tlb_we,
    input  wire  [$clog2(tlb_entries)-1:0] tlb_idx,
    input  wire  [18:0]                    tlb_vppn,
    input  wire  [5:0]                     tlb_ps,
    input  wire                            tlb_g,
    input  wire  [9:0]                     tlb_asid,
    input  wire                            tlb_e,
    input  wire  [19:0]                    tlb_ppn0,
    input  wire  [19:0]                    tlb_ppn1,
    input  wire  [1:0]                     tlb_plv0,
    input  wire  [1:0]                     tlb_plv1,
    input  wire  [1:0]                     tlb_mat0,
    input  wire  [1:0]                     tlb_mat1,
    input  wire                            tlb_d0,
    input  wire                            tlb_d1,
    input  wire                            tlb_v0,
    input  wire                            tlb_v1,

    // translation request and response
    input  wire                            req_valid,
    input  wire  [31:0]                    req_va,
    input  wire  [1:0]                     req_kind,
    output logic                           resp_valid,
    output logic [31:0]                    resp_pa,
    output logic                           resp_cacheable,
    output logic                           resp_tlb_map,
    output logic [2:0]                     resp_exc
);

    logic [31:0] crmd;
    logic [31:0] asid;
    logic [31:0] dmw0;
    logic [31:0] dmw1;
    tlb_entry_t  tlb_wentry;
    req_kind_t   req_kind_e;
    mmu_exc_t    resp_exc_e;

    tlb_lookup_if tlb_lookup_bus ();

    assign tlb_wentry = '{
        vppn: tlb_vppn, ps: tlb_ps, g: tlb_g, asid: tlb_asid, e: tlb_e,
        ppn0: tlb_ppn0, plv0: tlb_plv0, mat0: tlb_mat0, d0: tlb_d0, v0: tlb_v0,
        ppn1: tlb_ppn1, plv1: tlb_plv1, mat1: tlb_mat1, d1: tlb_d1, v1: tlb_v1
    };
    assign req_kind_e = req_kind_t'(req_kind);
    assign resp_exc   = resp_exc_e;

    mmu_csr_regs mmu_csr_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_we    (csr_we),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .crmd      (crmd),
        .asid      (asid),
        .dmw0      (dmw0),
        .dmw1      (dmw1)
    );

    tlb_array #(
        .tlb_entries (tlb_entries)
    ) tlb_array_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .tlb_we     (tlb_we),
        .tlb_idx    (tlb_idx),
        .tlb_wentry (tlb_wentry),
        .lookup     (tlb_lookup_bus.responder)
    );

    addr_translate addr_translate_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_va         (req_va),
        .req_kind       (req_kind_e),
        .crmd           (crmd),
        .asid           (asid),
        .dmw0           (dmw0),
        .dmw1           (dmw1),
        .tlb            (tlb_lookup_bus.requester),
        .resp_valid     (resp_valid),
        .resp_pa        (resp_pa),
        .resp_cacheable (resp_cacheable),
        .resp_tlb_map   (resp_tlb_map),
        .resp_exc       (resp_exc_e)
    );

endmodule

`default_nettype wire

/* src.f */
la_mmu_pkg.sv
la_csr_pkg.sv
tlb_lookup_if.sv
mmu_csr_regs.sv
tlb_array.sv
addr_translate.sv
mmu_top.sv
tb_mmu.sv

/* tb_mmu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mmu
    import la_mmu_pkg::*;
    import la_csr_pkg::*;
();

    localparam int tlb_entries    = 16;
    localparam int idx_w          = $clog2(tlb_entries);
    localparam int reset_cycles   = 16;
    localparam int direct_reqs    = 20;
    localparam int num_ops        = 2000;
    localparam int drive_delay    = 10;
    // whole run is a little over num_ops cycles
    localparam int timeout_cycles = 2 * num_ops;

    typedef struct packed {
        logic [31:0] stamp;
        logic [31:0] pa;
        logic        cacheable;
        logic        tlb_map;
        logic [2:0]  exc;
    } expect_t;

    // starts low so the first clock event is a rising edge
    logic             clk = 1'b0;
    logic             rst_n;
    logic             csr_we;
    logic [13:0]      csr_addr;
    logic [31:0]      csr_wdata;
    logic             tlb_we;
    logic [idx_w-1:0] tlb_idx;
    tlb_entry_t       fill_entry;
    logic             req_valid;
    logic [31:0]      req_va;
    logic [1:0]       req_kind;
    wire              resp_valid;
    wire  [31:0]      resp_pa;
    wire              resp_cacheable;
    wire              resp_tlb_map;
    wire  [2:0]       resp_exc;

    // reference state
    logic [31:0]      m_crmd;
    logic [31:0]      m_asid;
    logic [31:0]      m_dmw0;
    logic [31:0]      m_dmw1;
    tlb_entry_t       m_tlb [tlb_entries];

    expect_t          exp_q [$];
    integer           seed;
    int               cycle_count = 0;

    mmu_top #(
        .tlb_entries (tlb_entries)
    ) mmu_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .csr_we         (csr_we),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .tlb_we         (tlb_we),
        .tlb_idx        (tlb_idx),
        .tlb_vppn       (fill_entry.vppn),
        .tlb_ps         (fill_entry.ps),
        .tlb_g          (fill_entry.g),
        .tlb_asid       (fill_entry.asid),
        .tlb_e          (fill_entry.e),
        .tlb_ppn0       (fill_entry.ppn0),
        .tlb_ppn1       (fill_entry.ppn1),
        .tlb_plv0       (fill_entry.plv0),
        .tlb_plv1       (fill_entry.plv1),
        .tlb_mat0       (fill_entry.mat0),
        .tlb_mat1       (fill_entry.mat1),
        .tlb_d0         (fill_entry.d0),
        .tlb_d1         (fill_entry.d1),
        .tlb_v0         (fill_entry.v0),
        .tlb_v1         (fill_entry.v1),
        .req_valid      (req_valid),
        .req_va         (req_va),
        .req_kind       (req_kind),
        .resp_valid     (resp_valid),
        .resp_pa        (resp_pa),
        .resp_cacheable (resp_cacheable),
        .resp_tlb_map   (resp_tlb_map),
        .resp_exc       (resp_exc)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic stop_run;
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] w;
        w = $random(seed);
        return int'(w[30:0]) % n;
    endfunction

    function automatic logic [1:0] random_kind();
        return 2'(rand_below(3));
    endfunction

    function automatic tlb_entry_t random_entry();
        tlb_entry_t  ent;
        logic [31:0] w;
        logic [31:0] p;
        w = rand_word();
        p = rand_word();
        ent = '0;
        // shared tags now and then, so several entries can match
        if (rand_below(4) == 0) begin
            ent.vppn = m_tlb[rand_below(tlb_entries)].vppn;
        end else begin
            ent.vppn = w[18:0];
        end
        ent.ps   = (rand_below(2) == 0) ? ps_4k : ps_2m;
        ent.g    = (rand_below(4) == 0);
        ent.asid = 10'(rand_below(4));
        ent.e    = (rand_below(10) != 0);
        ent.ppn0 = p[19:0];
        ent.ppn1 = {p[31:20], w[26:19]};
        ent.plv0 = 2'(rand_below(4));
        ent.plv1 = 2'(rand_below(4));
        ent.mat0 = w[28:27];
        ent.mat1 = w[30:29];
        ent.d0   = (rand_below(2) == 0);
        ent.d1   = (rand_below(2) == 0);
        ent.v0   = (rand_below(5) != 0);
        ent.v1   = (rand_below(5) != 0);
        return ent;
    endfunction

    // steer toward window segments and filled pages
    function automatic logic [31:0] random_va();
        logic [31:0] w;
        tlb_entry_t  ent;
        int          sel;
        w   = rand_word();
        sel = rand_below(4);
        ent = m_tlb[rand_below(tlb_entries)];
        if (sel == 0) begin
            return w;
        end else if (sel == 1) begin
            if (rand_below(2) == 0) begin
                return {m_dmw0[dmw_vseg_msb:dmw_vseg_lsb], w[28:0]};
            end
            return {m_dmw1[dmw_vseg_msb:dmw_vseg_lsb], w[28:0]};
        end else if (ent.ps == ps_2m) begin
            return {ent.vppn[18:9], w[21:0]};
        end
        return {ent.vppn, w[12:0]};
    endfunction

    function automatic logic entry_matches(input tlb_entry_t ent, input logic [31:0] va);
        if (!ent.e) begin
            return 1'b0;
        end
        if (!ent.g && (ent.asid != m_asid[9:0])) begin
            return 1'b0;
        end
        if (ent.ps == ps_2m) begin
            return ent.vppn[18:9] == va[31:22];
        end
        return ent.vppn == va[31:13];
    endfunction

    function automatic expect_t predict(input logic [31:0] va, input logic [1:0] kind);
        expect_t     r;
        logic [1:0]  plv;
        logic        mapped;
        logic        win0;
        logic        win1;
        int          hit;
        tlb_entry_t  ent;
        logic        odd;
        logic [19:0] ppn;
        logic [1:0]  pplv;
        logic [1:0]  pmat;
        logic        pd;
        logic        pv;
        r      = '0;
        hit    = -1;
        plv    = m_crmd[crmd_plv_msb:crmd_plv_lsb];
        mapped = !m_crmd[crmd_da] && m_crmd[crmd_pg];
        win0   = mapped && m_dmw0[plv] && (m_dmw0[31:29] == va[31:29]);
        win1   = mapped && m_dmw1[plv] && (m_dmw1[31:29] == va[31:29]);
        if (!mapped) begin
            r.pa        = va;
            r.cacheable = m_crmd[crmd_datm_lsb];
        end else if (win0) begin
            r.pa        = {m_dmw0[27:25], va[28:0]};
            r.cacheable = m_dmw0[dmw_mat];
        end else if (win1) begin
            r.pa        = {m_dmw1[27:25], va[28:0]};
            r.cacheable = m_dmw1[dmw_mat];
        end else begin
            r.tlb_map = 1'b1;
            for (int i = 0; i < tlb_entries; i++) begin
                if (hit < 0 && entry_matches(m_tlb[i], va)) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                r.exc = exc_tlbr;
            end else begin
                ent  = m_tlb[hit];
                odd  = (ent.ps == ps_2m) ? va[21] : va[12];
                ppn  = odd ? ent.ppn1 : ent.ppn0;
                pplv = odd ? ent.plv1 : ent.plv0;
                pmat = odd ? ent.mat1 : ent.mat0;
                pd   = odd ? ent.d1 : ent.d0;
                pv   = odd ? ent.v1 : ent.v0;
                r.pa = (ent.ps == ps_2m) ? {ppn[19:9], va[20:0]} : {ppn, va[11:0]};
                r.cacheable = pmat[0];
                if (!pv) begin
                    r.exc = exc_pix;
                end else if (plv > pplv) begin
                    r.exc = exc_ppi;
                end else if (kind == req_store && !pd) begin
                    r.exc = exc_pme;
                end else begin
                    r.exc = exc_none;
                end
            end
        end
        return r;
    endfunction

    task automatic clear_strobes;
        req_valid = 1'b0;
        tlb_we    = 1'b0;
        csr_we    = 1'b0;
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #drive_delay;
        clear_strobes();
    endtask

    // predicted from the state before this cycle's writes
    task automatic send_request(input logic [31:0] va, input logic [1:0] kind);
        expect_t e;
        e       = predict(va, kind);
        e.stamp = 32'(cycle_count);
        exp_q.push_back(e);
        req_valid = 1'b1;
        req_va    = va;
        req_kind  = kind;
    endtask

    task automatic load_entry(input int idx, input tlb_entry_t ent);
        tlb_we      = 1'b1;
        tlb_idx     = idx_w'(idx);
        fill_entry  = ent;
        m_tlb[idx]  = ent;
    endtask

    task automatic write_csr(input logic [13:0] addr, input logic [31:0] data);
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        case (addr)
            csr_crmd: m_crmd = data;
            csr_asid: m_asid = data;
            csr_dmw0: m_dmw0 = data;
            csr_dmw1: m_dmw1 = data;
            default: begin
                // unknown CSR numbers leave the registers untouched
            end
        endcase
    endtask

    task automatic random_csr_write;
        logic [31:0] w;
        logic        mapped;
        int          sel;
        w      = rand_word();
        sel    = rand_below(5);
        mapped = (rand_below(4) != 0);
        if (sel == 0) begin
            // only the two legal da/pg pairs
            w[crmd_da] = !mapped;
            w[crmd_pg] = mapped;
            write_csr(csr_crmd, w);
        end else if (sel == 1) begin
            write_csr(csr_asid, w & 32'hffff_fc03);
        end else if (sel == 2) begin
            write_csr(csr_dmw0, w);
        end else if (sel == 3) begin
            write_csr(csr_dmw1, w);
        end else begin
            write_csr(14'h006, w);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the test did not finish", cycle_count);
            stop_run();
        end
    end

    // responses are stable by the falling edge
    always @(negedge clk) begin
        expect_t due;
        if (exp_q.size() > 0 && exp_q[0].stamp == 32'(cycle_count - 1)) begin
            due = exp_q.pop_front();
            assert (resp_valid === 1'b1) else begin
                $display("Fail %0t resp_valid expected 1 got %b", $time, resp_valid);
                stop_run();
            end
            assert (resp_exc === due.exc) else begin
                $display("Fail %0t resp_exc expected %0d got %0d", $time, due.exc, resp_exc);
                stop_run();
            end
            assert (resp_tlb_map === due.tlb_map) else begin
                $display("Fail %0t resp_tlb_map expected %b got %b",
                         $time, due.tlb_map, resp_tlb_map);
                stop_run();
            end
            // a refill has no page behind it
            if (due.exc != exc_tlbr) begin
                assert (resp_pa === due.pa) else begin
                    $display("Fail %0t resp_pa expected %h got %h", $time, due.pa, resp_pa);
                    stop_run();
                end
                assert (resp_cacheable === due.cacheable) else begin
                    $display("Fail %0t resp_cacheable expected %b got %b",
                             $time, due.cacheable, resp_cacheable);
                    stop_run();
                end
            end
        end else begin
            assert (resp_valid === 1'b0) else begin
                $display("Fail %0t resp_valid expected 0 got %b", $time, resp_valid);
                stop_run();
            end
        end
    end

    initial begin
        int op;
        seed       = 32'h3488_3a6c;
        rst_n      = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
        tlb_idx    = '0;
        fill_entry = '0;
        req_va     = '0;
        req_kind   = '0;
        clear_strobes();
        m_crmd = crmd_reset;
        m_asid = '0;
        m_dmw0 = '0;
        m_dmw1 = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            m_tlb[i] = '0;
        end

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        // direct mode out of reset
        repeat (direct_reqs) begin
            next_cycle();
            send_request(rand_word(), random_kind());
        end

        for (int i = 0; i < tlb_entries; i++) begin
            next_cycle();
            load_entry(i, random_entry());
        end

        next_cycle();
        write_csr(csr_asid, rand_word() & 32'hffff_fc03);
        next_cycle();
        write_csr(csr_dmw0, rand_word());
        next_cycle();
        write_csr(csr_dmw1, rand_word());
        next_cycle();
        write_csr(csr_crmd, 32'h0000_0010);

        repeat (num_ops) begin
            next_cycle();
            op = rand_below(10);
            if (op < 8) begin
                send_request(random_va(), random_kind());
            end else begin
                // half of the writes share the cycle with a request
                if (rand_below(2) == 0) begin
                    send_request(random_va(), random_kind());
                end
                if (op == 8) begin
                    load_entry(rand_below(tlb_entries), random_entry());
                end else begin
                    random_csr_write();
                end
            end
        end

        next_cycle();
        repeat (3) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d expected responses never arrived", exp_q.size());
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* tlb_array.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_array
    import la_mmu_pkg::*;
#(
    parameter int tlb_entries = 16
) (
    input  wire                               clk,
    input  wire                               rst_n,

    // fill port
    input  wire                               tlb_we,
    input  wire  [$clog2(tlb_entries)-1:0]    tlb_idx,
    input  tlb_entry_t                        tlb_wentry,

    // combinational lookup
    tlb_lookup_if.responder                   lookup
);

    localparam int idx_w = $clog2(tlb_entries);

    tlb_entry_t             entry_q [tlb_entries];
    logic [tlb_entries-1:0] exist_q;

    logic [tlb_entries-1:0] vppn_eq;
    logic [tlb_entries-1:0] asid_eq;
    logic [tlb_entries-1:0] hit;
    logic                   hit_any;
    logic [idx_w-1:0]       hit_idx;
    tlb_entry_t             hit_entry;
    logic                   odd_page;

    // entry payload, only meaningful while its exist bit is set
    always_ff @(posedge clk) begin
        if (tlb_we) begin
            entry_q[tlb_idx] <= tlb_wentry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exist_q <= '0;
        end else if (tlb_we) begin
            exist_q[tlb_idx] <= tlb_wentry.e;
        end
    end

    // per-entry match
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            // a 2M page ignores the low 9 vppn bits
            if (entry_q[i].ps == ps_2m) begin
                vppn_eq[i] = (entry_q[i].vppn[18:9] == lookup.vppn[18:9]);
            end else begin
                vppn_eq[i] = (entry_q[i].vppn == lookup.vppn);
            end
            asid_eq[i] = entry_q[i].g || (entry_q[i].asid == lookup.asid);
            hit[i]     = exist_q[i] && asid_eq[i] && vppn_eq[i];
        end
    end

    // lowest matching index wins, so scan downward
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_any = 1'b1;
                hit_idx = idx_w'(i);
            end
        end
    end

    // even/odd page select and result drive
    always_comb begin
        hit_entry = entry_q[hit_idx];
        if (hit_entry.ps == ps_2m) begin
            // address bit 21 picks the page of a 2M pair
            odd_page = lookup.vppn[8];
        end else begin
            odd_page = lookup.va_bit12;
        end

        lookup.found = hit_any;
        if (!hit_any) begin
            // a miss returns an all-zero page
            lookup.ppn = '0;
            lookup.ps  = '0;
            lookup.plv = '0;
            lookup.mat = '0;
            lookup.d   = 1'b0;
            lookup.v   = 1'b0;
        end else if (odd_page) begin
            lookup.ppn = hit_entry.ppn1;
            lookup.ps  = hit_entry.ps;
            lookup.plv = hit_entry.plv1;
            lookup.mat = hit_entry.mat1;
            lookup.d   = hit_entry.d1;
            lookup.v   = hit_entry.v1;
        end else begin
            lookup.ppn = hit_entry.ppn0;
            lookup.ps  = hit_entry.ps;
            lookup.plv = hit_entry.plv0;
            lookup.mat = hit_entry.mat0;
            lookup.d   = hit_entry.d0;
            lookup.v   = hit_entry.v0;
        end
    end

endmodule

`default_nettype wire

/* tlb_lookup_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface tlb_lookup_if;

    // query
    logic [18:0] vppn;
    logic        va_bit12;
    logic [9:0]  asid;

    // result of the selected page
    logic        found;
    logic [19:0] ppn;
    logic [5:0]  ps;
    logic [1:0]  plv;
    logic [1:0]  mat;
    logic        d;
    logic        v;

    modport requester (
        output vppn, va_bit12, asid,
        input  found, ppn, ps, plv, mat, d, v
    );

    modport responder (
        input  vppn, va_bit12, asid,
        output found, ppn, ps, plv, mat, d, v
    );

endinterface

`default_nettype wire
